// ==== rtl/xgmii_xbar_pkg.sv ====
/*
 * xgmii crossbar package with the lane count, the lane vector types,
 * the xgmii idle pattern and the bit layout of a map register
 */
package xgmii_xbar_pkg;

   // ~~~~~~~~~~~~~~~~~~~~
   // lane geometry
   // ~~~~~~~~~~~~~~~~~~~~

   localparam int xgmii_count = 4;  // receive lanes, and also transmit lanes

   // width of a lane number, kept at one bit or more for a single lane build
   localparam int sel_width = (xgmii_count > 1) ? $clog2(xgmii_count) : 1;

   // ~~~~~~~~~~~~~~~~~~~~
   // vector types
   // ~~~~~~~~~~~~~~~~~~~~

   typedef logic [63:0] xgmii_data_t;           // one sdr data word of a lane
   typedef logic [7:0] xgmii_ctrl_t;            // one control bit per data byte
   typedef logic [sel_width-1:0] lane_sel_t;    // number of a receive lane
   typedef logic [31:0] mi32_word_t;            // mi32 data and address
   typedef logic [3:0] mi32_be_t;               // mi32 byte enables

   // ~~~~~~~~~~~~~~~~~~~~
   // idle pattern
   // ~~~~~~~~~~~~~~~~~~~~

   // every byte carries the idle control character 0x07
   localparam xgmii_data_t xgmii_idle_data = {8{8'h07}};

   // all control bits set, so every byte is a control character
   localparam xgmii_ctrl_t xgmii_idle_ctrl = '1;

   // ~~~~~~~~~~~~~~~~~~~~
   // map register layout
   // ~~~~~~~~~~~~~~~~~~~~

   // the source lane sits in the low sel_width bits of the register
   // and the output enable flag sits in the top byte, under be[3]
   localparam int map_enable_bit = 31;

endpackage : xgmii_xbar_pkg

// ==== rtl/mi32_xbar_regs.sv ====
/*
 * mi32 register block of the xgmii crossbar, holding one map register
 * per output with the source lane and the output enable flag
 */
`timescale 1ns/1ns

module mi32_xbar_regs (
   input  logic                                                 clk,
   input  logic                                                 rst_n,
   // mi32 slave
   input  xgmii_xbar_pkg::mi32_word_t                           dwr,
   input  xgmii_xbar_pkg::mi32_word_t                           addr,
   input  logic                                                 rd,
   input  logic                                                 wr,
   input  xgmii_xbar_pkg::mi32_be_t                             be,
   output xgmii_xbar_pkg::mi32_word_t                           drd,
   output logic                                                 ardy,
   output logic                                                 drdy,
   // map table towards the lane switch
   output xgmii_xbar_pkg::lane_sel_t [xgmii_xbar_pkg::xgmii_count-1:0] out_sel,
   output logic [xgmii_xbar_pkg::xgmii_count-1:0]               out_en
);

   import xgmii_xbar_pkg::*;

   logic [29:0] word_addr;  // byte address dropped to a 32-bit word address
   logic        addr_hit;   // high when the word address names a map register
   lane_sel_t   word_idx;   // output whose map register is addressed
   mi32_word_t  map_word;   // addressed map register in its mi32 layout

   // ~~~~~~~~~~~~~~~~~~~~
   // address decode
   // ~~~~~~~~~~~~~~~~~~~~

   assign word_addr = addr[31:2];                   // addr[1:0] only picks a byte
   assign addr_hit  = (word_addr < 30'(xgmii_count)); // one register per output
   assign word_idx  = word_addr[sel_width-1:0];     // valid only together with addr_hit

   // every request is taken in the cycle it shows up
   assign ardy = rd | wr;

   // pack the addressed row, unused bits read back as zero
   always_comb begin
      map_word                 = '0;
      map_word[sel_width-1:0]  = out_sel[word_idx];  // source lane in the low bits
      map_word[map_enable_bit] = out_en[word_idx];   // enable flag at the top
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // map table
   // ~~~~~~~~~~~~~~~~~~~~

   // reset gives the identity map with all outputs on, so traffic passes
   // straight through until software programs something else
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < xgmii_count; i++) begin
            out_sel[i] <= lane_sel_t'(i);  // output i fed from input i
         end
         out_en <= '1;                     // every output enabled
      end else if (wr && addr_hit) begin
         if (be[0]) begin
            out_sel[word_idx] <= dwr[sel_width-1:0];  // low byte holds the source
         end
         if (be[3]) begin
            out_en[word_idx] <= dwr[map_enable_bit];  // top byte holds the enable
         end
      end
      // writes outside the table fall through and change nothing
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // read path
   // ~~~~~~~~~~~~~~~~~~~~

   // drdy follows the accepted rd by exactly one clock
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         drdy <= 1'b0;   // no read in flight out of reset
      end else begin
         drdy <= rd;     // one cycle read latency
      end
   end

   // data is captured together with the rd that asked for it
   always_ff @(posedge clk) begin
      if (rd) begin
         drd <= addr_hit ? map_word : '0;  // unmapped addresses read as zero
      end
   end

endmodule : mi32_xbar_regs

// ==== rtl/xgmii_lane_switch.sv ====
/*
 * xgmii lane switch, one registered selector per transmit lane that
 * forwards the chosen receive lane or sends idle while disabled
 */
`timescale 1ns/1ns

module xgmii_lane_switch (
   input  logic                                                   clk,
   input  logic                                                   rst_n,
   // receive lanes, all sampled on clk
   input  xgmii_xbar_pkg::xgmii_data_t [xgmii_xbar_pkg::xgmii_count-1:0] rxd,
   input  xgmii_xbar_pkg::xgmii_ctrl_t [xgmii_xbar_pkg::xgmii_count-1:0] rxc,
   // map table from the register block
   input  xgmii_xbar_pkg::lane_sel_t [xgmii_xbar_pkg::xgmii_count-1:0]   out_sel,
   input  logic [xgmii_xbar_pkg::xgmii_count-1:0]                         out_en,
   // transmit lanes
   output xgmii_xbar_pkg::xgmii_data_t [xgmii_xbar_pkg::xgmii_count-1:0] txd,
   output xgmii_xbar_pkg::xgmii_ctrl_t [xgmii_xbar_pkg::xgmii_count-1:0] txc
);

   import xgmii_xbar_pkg::*;

   // ~~~~~~~~~~~~~~~~~~~~
   // per output selector
   // ~~~~~~~~~~~~~~~~~~~~

   // each output looks only at its own map entry, so several outputs may
   // name the same input and receive the same stream (broadcast)
   for (genvar o = 0; o < xgmii_count; o++) begin : g_out

      xgmii_data_t sel_data;  // word chosen for this output in the current cycle
      xgmii_ctrl_t sel_ctrl;  // control bits that go with sel_data

      // the mux follows out_sel directly, so a new map is used by the very
      // next word that is registered after the register block updates
      always_comb begin
         if (out_en[o]) begin
            sel_data = rxd[out_sel[o]];  // forward the mapped input lane
            sel_ctrl = rxc[out_sel[o]];
         end else begin
            sel_data = xgmii_idle_data;  // disabled output keeps a clean idle stream
            sel_ctrl = xgmii_idle_ctrl;
         end
      end

      // single register stage, giving one cycle from rx to tx
      always_ff @(posedge clk) begin
         if (!rst_n) begin
            txd[o] <= xgmii_idle_data;  // link partner sees idle during reset
            txc[o] <= xgmii_idle_ctrl;
         end else begin
            txd[o] <= sel_data;
            txc[o] <= sel_ctrl;
         end
      end

      // no frame boundary tracking here, so a remap mid frame
      // cuts that frame and software has to avoid it

   end : g_out

endmodule : xgmii_lane_switch

// ==== rtl/xgmii_crossbar_top.sv ====
/*
 * xgmii crossbar top level, joining the mi32 map registers
 * to the registered lane switch
 */
`timescale 1ns/1ns

module xgmii_crossbar_top (
   input  logic                                                   clk,
   input  logic                                                   rst_n,
   // xgmii receive lanes
   input  xgmii_xbar_pkg::xgmii_data_t [xgmii_xbar_pkg::xgmii_count-1:0] rxd,
   input  xgmii_xbar_pkg::xgmii_ctrl_t [xgmii_xbar_pkg::xgmii_count-1:0] rxc,
   // xgmii transmit lanes
   output xgmii_xbar_pkg::xgmii_data_t [xgmii_xbar_pkg::xgmii_count-1:0] txd,
   output xgmii_xbar_pkg::xgmii_ctrl_t [xgmii_xbar_pkg::xgmii_count-1:0] txc,
   // mi32 slave
   input  xgmii_xbar_pkg::mi32_word_t                             dwr,
   input  xgmii_xbar_pkg::mi32_word_t                             addr,
   input  logic                                                   rd,
   input  logic                                                   wr,
   input  xgmii_xbar_pkg::mi32_be_t                               be,
   output xgmii_xbar_pkg::mi32_word_t                             drd,
   output logic                                                   ardy,
   output logic                                                   drdy
);

   import xgmii_xbar_pkg::*;

   lane_sel_t [xgmii_count-1:0] out_sel;  // source lane of every output
   logic [xgmii_count-1:0]      out_en;   // output enable flags

   // ~~~~~~~~~~~~~~~~~~~~
   // map registers
   // ~~~~~~~~~~~~~~~~~~~~

   mi32_xbar_regs u_regs (
      .clk     (clk),
      .rst_n   (rst_n),
      .dwr     (dwr),
      .addr    (addr),
      .rd      (rd),
      .wr      (wr),
      .be      (be),
      .drd     (drd),
      .ardy    (ardy),
      .drdy    (drdy),
      .out_sel (out_sel),
      .out_en  (out_en)
   );

   // ~~~~~~~~~~~~~~~~~~~~
   // lane switch
   // ~~~~~~~~~~~~~~~~~~~~

   xgmii_lane_switch u_switch (
      .clk     (clk),
      .rst_n   (rst_n),
      .rxd     (rxd),
      .rxc     (rxc),
      .out_sel (out_sel),
      .out_en  (out_en),
      .txd     (txd),
      .txc     (txc)
   );

endmodule : xgmii_crossbar_top

// ==== bench/tb_xbar_checks.svh ====
/*
 * testbench helpers for the xgmii crossbar, with mi32 bus tasks
 * and compare tasks for data words, control bits and registers
 */
`ifndef TB_XBAR_CHECKS_SVH
`define TB_XBAR_CHECKS_SVH

   // ~~~~~~~~~~~~~~~~~~~~
   // compare tasks
   // ~~~~~~~~~~~~~~~~~~~~

   task automatic check_data(input string name, input xgmii_data_t exp, input xgmii_data_t act);
      if (act !== exp) begin
         $display("** Error: %s expected %h actual %h", name, exp, act);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   task automatic check_ctrl(input string name, input xgmii_ctrl_t exp, input xgmii_ctrl_t act);
      if (act !== exp) begin
         $display("** Error: %s expected %h actual %h", name, exp, act);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   task automatic check_reg(input string name, input mi32_word_t exp, input mi32_word_t act);
      if (act !== exp) begin
         $display("** Error: %s expected %h actual %h", name, exp, act);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   // single handshake bits such as ardy and drdy
   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("** Error: %s expected %b actual %b", name, exp, act);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   // read latency in clock cycles from rd to drdy
   task automatic check_latency(input string name, input int exp, input int act);
      if (act != exp) begin
         $display("** Error: %s expected %0d actual %0d", name, exp, act);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~
   // mi32 bus tasks
   // ~~~~~~~~~~~~~~~~~~~~

   // starts and ends on a falling edge, the write lands on the edge in between
   task automatic mi32_write(input mi32_word_t a, input mi32_be_t b, input mi32_word_t d);
      addr = a;
      be   = b;
      dwr  = d;
      wr   = 1'b1;
      @(posedge clk);
      check_flag($sformatf("write %h ardy", a), 1'b1, ardy);  // taken at this edge
      @(negedge clk);
      wr   = 1'b0;  // single cycle request
   endtask

   task automatic mi32_read(input string name, input mi32_word_t a, output mi32_word_t d);
      int cycles;
      cycles = 0;
      addr   = a;
      rd     = 1'b1;
      @(posedge clk);
      check_flag({name, " ardy"}, 1'b1, ardy);  // request accepted at once
      do begin
         @(negedge clk);
         rd = 1'b0;   // the request was taken at the rising edge
         cycles++;
      end while (!drdy && cycles < read_timeout);
      if (!drdy) begin
         $display("read %s got no drdy within %0d cycles", name, read_timeout);
         $display("Test failed");
         $fatal(1);
      end
      check_latency({name, " latency"}, 1, cycles);
      d = drd;  // drd is valid in the drdy cycle
   endtask

`endif

// ==== bench/tb_xgmii_crossbar.sv ====
/*
 * testbench of the xgmii crossbar, runs the command lines of the tests
 * file against the DUT and a map model kept from the mi32 writes
 */
`timescale 1ns/1ns

module tb_xgmii_crossbar;

   import xgmii_xbar_pkg::*;

   localparam int read_timeout = 16;  // cycles allowed for drdy

   logic                          clk;
   logic                          rst_n;
   xgmii_data_t [xgmii_count-1:0] rxd;
   xgmii_ctrl_t [xgmii_count-1:0] rxc;
   xgmii_data_t [xgmii_count-1:0] txd;
   xgmii_ctrl_t [xgmii_count-1:0] txc;
   mi32_word_t                    dwr;
   mi32_word_t                    addr;
   logic                          rd;
   logic                          wr;
   mi32_be_t                      be;
   mi32_word_t                    drd;
   logic                          ardy;
   logic                          drdy;

   lane_sel_t   model_sel [xgmii_count];  // source lane the model expects per output
   logic        model_en  [xgmii_count];  // enable flag the model expects per output

   `include "tb_xbar_checks.svh"

   xgmii_crossbar_top u_dut (
      .clk   (clk),
      .rst_n (rst_n),
      .rxd   (rxd),
      .rxc   (rxc),
      .txd   (txd),
      .txc   (txc),
      .dwr   (dwr),
      .addr  (addr),
      .rd    (rd),
      .wr    (wr),
      .be    (be),
      .drd   (drd),
      .ardy  (ardy),
      .drdy  (drdy)
   );

   always #20 clk = ~clk;  // 40 ns period

   // ~~~~~~~~~~~~~~~~~~~~
   // map model
   // ~~~~~~~~~~~~~~~~~~~~

   task automatic model_write(input mi32_word_t a, input mi32_be_t b, input mi32_word_t d);
      int idx;
      idx = a[31:2];                        // word address
      if (idx < xgmii_count) begin          // higher addresses are ignored
         if (b[0]) model_sel[idx] = d[sel_width-1:0];
         if (b[3]) model_en[idx] = d[map_enable_bit];
      end
   endtask

   function automatic mi32_word_t model_read(input mi32_word_t a);
      int         idx;
      mi32_word_t w;
      idx = a[31:2];
      w   = '0;                             // unmapped words read zero
      if (idx < xgmii_count) begin
         w[sel_width-1:0]  = model_sel[idx];
         w[map_enable_bit] = model_en[idx];
      end
      return w;
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~
   // tests file parsing
   // ~~~~~~~~~~~~~~~~~~~~

   // every command has a fixed number of fields on its line
   task automatic check_fields(input string name, input int want, input int got);
      if (got != want) begin
         $display("line %s has %0d fields where %0d are needed", name, got, want);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~
   // traffic
   // ~~~~~~~~~~~~~~~~~~~~

   // one rx cycle, lane gets the given word and the rest random words,
   // a lane of -1 makes every lane random
   task automatic send_cycle(input string name, input int lane,
                             input xgmii_data_t d, input xgmii_ctrl_t c);
      xgmii_data_t exp_d;
      xgmii_ctrl_t exp_c;
      for (int l = 0; l < xgmii_count; l++) begin
         rxd[l] = (l == lane) ? d : {$urandom, $urandom};
         rxc[l] = (l == lane) ? c : xgmii_ctrl_t'($urandom);
      end
      @(negedge clk);                       // tx now holds the rx of this cycle
      check_flag({name, " ardy"}, 1'b0, ardy);  // no mi32 request in traffic cycles
      for (int o = 0; o < xgmii_count; o++) begin
         exp_d = model_en[o] ? rxd[model_sel[o]] : {8{8'h07}};  // idle when off
         exp_c = model_en[o] ? rxc[model_sel[o]] : 8'hff;
         check_data($sformatf("%s txd%0d", name, o), exp_d, txd[o]);
         check_ctrl($sformatf("%s txc%0d", name, o), exp_c, txc[o]);
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~
   // test sequence
   // ~~~~~~~~~~~~~~~~~~~~

   initial begin
      int          fd;
      int          n;
      int          tests_run;
      string       line;
      string       cmd;
      string       name;
      mi32_word_t  arg_addr;
      mi32_be_t    arg_be;
      mi32_word_t  arg_word;
      mi32_word_t  rd_word;
      int          arg_num;
      xgmii_data_t arg_data;
      xgmii_ctrl_t arg_ctrl;
      void'($urandom(99));                  // one seed for the whole run
      clk       = 1'b0;
      rst_n     = 1'b0;
      rxd       = '0;
      rxc       = '0;
      dwr       = '0;
      addr      = '0;
      rd        = 1'b0;
      wr        = 1'b0;
      be        = '0;
      tests_run = 0;
      for (int i = 0; i < xgmii_count; i++) begin
         model_sel[i] = lane_sel_t'(i);     // identity map after reset
         model_en[i]  = 1'b1;
      end
      repeat (8) @(posedge clk);
      @(negedge clk);
      for (int o = 0; o < xgmii_count; o++) begin
         check_data($sformatf("reset txd%0d", o), {8{8'h07}}, txd[o]);
         check_ctrl($sformatf("reset txc%0d", o), 8'hff, txc[o]);
      end
      check_flag("reset drdy", 1'b0, drdy);  // no read in flight out of reset
      rst_n = 1'b1;
      fd = $fopen("bench/xgmii_crossbar_tests.txt", "r");
      if (fd == 0) begin
         $display("could not open the tests file");
         $display("Test failed");
         $fatal(1);
      end
      while ($fgets(line, fd)) begin
         if (line.len() < 2 || line[0] == "#") continue;  // blank or column notes
         n = $sscanf(line, "%s %s", cmd, name);
         check_fields(line, 2, n);
         if (cmd == "wr") begin
            n = $sscanf(line, "%s %s %h %h %h", cmd, name, arg_addr, arg_be, arg_word);
            check_fields(name, 5, n);
            mi32_write(arg_addr, arg_be, arg_word);
            model_write(arg_addr, arg_be, arg_word);
         end else if (cmd == "rd") begin
            n = $sscanf(line, "%s %s %h %h", cmd, name, arg_addr, arg_word);
            check_fields(name, 4, n);
            mi32_read(name, arg_addr, rd_word);
            check_reg(name, arg_word, rd_word);
            check_reg({name, " model"}, model_read(arg_addr), rd_word);
         end else if (cmd == "rnd") begin
            n = $sscanf(line, "%s %s %d", cmd, name, arg_num);
            check_fields(name, 3, n);
            for (int k = 0; k < arg_num; k++) begin
               send_cycle(name, -1, '0, '0);
            end
         end else if (cmd == "word") begin
            n = $sscanf(line, "%s %s %d %h %h", cmd, name, arg_num, arg_data, arg_ctrl);
            check_fields(name, 5, n);
            send_cycle(name, arg_num, arg_data, arg_ctrl);
         end else if (cmd == "exp") begin
            n = $sscanf(line, "%s %s %d %h %h", cmd, name, arg_num, arg_data, arg_ctrl);
            check_fields(name, 5, n);
            check_data(name, arg_data, txd[arg_num]);  // tx of the last word line
            check_ctrl(name, arg_ctrl, txc[arg_num]);
         end else begin
            $display("unknown command %s in the tests file", cmd);
            $display("Test failed");
            $fatal(1);
         end
         tests_run++;
      end
      $fclose(fd);
      if (tests_run > 0) begin
         $display("Test passed");
         $finish;
      end else begin
         $display("the tests file held no commands");
         $display("Test failed");
         $fatal(1);
      end
   end

endmodule : tb_xgmii_crossbar

// ==== bench/xgmii_crossbar_tests.txt ====
# wr <name> <addr> <be> <data> | rd <name> <addr> <expected> | rnd <name> <cycles>
# word <name> <rx lane> <data> <ctrl> | exp <name> <tx lane> <data> <ctrl>
rd reset_map0 00000000 80000000
rd reset_map1 00000004 80000001
rd reset_map2 00000008 80000002
rd reset_map3 0000000c 80000003
word reset_word 2 0123456789abcdef 01
exp reset_out2 2 0123456789abcdef 01
rnd reset_rnd 16
wr perm0 00000000 f 80000003
wr perm1 00000004 f 80000002
wr perm2 00000008 f 80000000
wr perm3 0000000c f 80000001
word perm_word 0 deadbeefcafef00d 00
exp perm_out2 2 deadbeefcafef00d 00
rnd perm_rnd 20
wr bcast0 00000000 f 80000001
wr bcast1 00000004 f 80000001
wr bcast2 00000008 f 80000001
wr bcast3 0000000c f 80000001
word bcast_word 1 fb555555555555d5 01
exp bcast_out0 0 fb555555555555d5 01
exp bcast_out3 3 fb555555555555d5 01
rnd bcast_rnd 20
wr dis2 00000008 8 00000000
word dis_word 1 1122334455667788 00
exp dis_out2 2 0707070707070707 ff
exp dis_out1 1 1122334455667788 00
rnd dis_rnd 16
rd dis_read2 00000008 00000001
wr be_src3 0000000c 1 00000002
rd be_read3 0000000c 80000002
wr be_en3 0000000c 8 00000003
rd be_read3b 0000000c 00000002
wr be_mid0 00000000 6 ffffffff
rd be_read0 00000000 80000001
wr be_on2 00000008 8 80000000
rd be_read2 00000008 80000001
rnd be_rnd 16
wr oob4 00000010 f 80000000
wr oob_far 00000100 f 00000003
rd oob_read4 00000010 00000000
rd oob_read_far 00000100 00000000
rd oob_map0 00000000 80000001
rnd oob_rnd 16

// ==== project.f ====
+incdir+bench
rtl/xgmii_xbar_pkg.sv
rtl/mi32_xbar_regs.sv
rtl/xgmii_lane_switch.sv
rtl/xgmii_crossbar_top.sv
bench/tb_xgmii_crossbar.sv
